// File: common/mem_arb_pkg.sv
package mem_arb_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and limits
    ////////////////////////////////////////////////////////////

    localparam int ADDR_W  = 32;                   // Byte address to main memory
    localparam int BLOCK_W = 64;                   // One memory block
    localparam int TAG_W   = 4;                    // Transaction tag, 0 is reserved

    // Usable tags are 1 .. 2**TAG_W-1
    localparam int NUM_TAGS = (1 << TAG_W) - 1;

    // Unaccepted icache cycles before it gets priority
    localparam int STARVE_LIMIT = 4;
    localparam int STARVE_CNT_W = $clog2(STARVE_LIMIT + 1);  // Holds 0 .. STARVE_LIMIT

    ////////////////////////////////////////////////////////////
    // Basic types
    ////////////////////////////////////////////////////////////

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [BLOCK_W-1:0] block_t;
    typedef logic [TAG_W-1:0]   mem_tag_t;      // 0 = not accepted / no data

    // Command bus toward memory
    typedef enum logic [1:0] {
        MEM_NONE  = 2'h0,                       // Idle bus
        MEM_LOAD  = 2'h1,                       // Read one block, data comes back tagged
        MEM_STORE = 2'h2                        // Write one block, no data returned
    } mem_command_e;

    // Owner of an outstanding transaction
    typedef enum logic {
        REQ_ICACHE = 1'b0,
        REQ_DCACHE = 1'b1
    } requester_e;

    ////////////////////////////////////////////////////////////
    // Cache side bundles
    ////////////////////////////////////////////////////////////

    // Request from one cache, held until its accepted strobe
    typedef struct packed {
        logic         valid;                    // Request pending
        mem_command_e command;                  // MEM_LOAD or MEM_STORE
        addr_t        addr;
        block_t       data;                     // Store data, ignored for loads
    } mem_req_t;

    // Returned load data, routed to the owning cache only
    typedef struct packed {
        logic     valid;                        // Data belongs to this cache
        mem_tag_t tag;                          // Tag handed out at acceptance
        block_t   data;
    } mem_resp_t;

endpackage

// File: hw/mem_arbiter/arb_fsm.sv
module arb_fsm (
    input  logic                      clock,
    input  logic                      rst_n,
    input  mem_arb_pkg::mem_req_t     icache_req,
    input  mem_arb_pkg::mem_req_t     dcache_req,
    input  mem_arb_pkg::mem_tag_t     mem2proc_transaction_tag,  // 0 = memory refused
    input  logic                      starved,                   // From starve_timer

    output mem_arb_pkg::mem_command_e proc2mem_command,
    output mem_arb_pkg::addr_t        proc2mem_addr,
    output mem_arb_pkg::block_t       proc2mem_data,
    output logic                      icache_accepted,
    output logic                      dcache_accepted,
    output mem_arb_pkg::requester_e   grant_owner,               // Who owns the bus this cycle
    output logic                      load_issued                // Accepted load, record its tag
);

    // Priority order of the two caches
    typedef enum logic {
        DCACHE_FIRST = 1'b0,                    // Normal mode, dcache wins ties
        ICACHE_FIRST = 1'b1                     // Icache waited too long
    } arb_state_e;

    arb_state_e            state;
    arb_state_e            state_next;
    logic                  icache_pref;         // Icache has priority this cycle
    logic                  mem_accept;          // Granted request taken by memory
    mem_arb_pkg::mem_req_t granted;             // Request placed on the bus

    ////////////////////////////////////////////////////////////
    // Requester selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        // Starved takes effect in the same cycle, the state only holds it
        icache_pref = (state == ICACHE_FIRST) || starved;

        if (icache_pref) begin
            grant_owner = icache_req.valid ? mem_arb_pkg::REQ_ICACHE
                                           : mem_arb_pkg::REQ_DCACHE;
        end else begin
            grant_owner = dcache_req.valid ? mem_arb_pkg::REQ_DCACHE
                                           : mem_arb_pkg::REQ_ICACHE;
        end

        granted = (grant_owner == mem_arb_pkg::REQ_ICACHE) ? icache_req : dcache_req;
    end

    ////////////////////////////////////////////////////////////
    // Memory bus and handshake
    ////////////////////////////////////////////////////////////

    always_comb begin
        // Idle bus unless the winner really has something
        proc2mem_command = granted.valid ? granted.command : mem_arb_pkg::MEM_NONE;
        proc2mem_addr    = granted.addr;
        proc2mem_data    = granted.data;  // Don't care on loads

        // Any nonzero tag is an acceptance
        mem_accept = granted.valid && (mem2proc_transaction_tag != '0);

        icache_accepted = mem_accept && (grant_owner == mem_arb_pkg::REQ_ICACHE);
        dcache_accepted = mem_accept && (grant_owner == mem_arb_pkg::REQ_DCACHE);

        // Stores get a tag too but never come back
        load_issued = mem_accept && (granted.command == mem_arb_pkg::MEM_LOAD);
    end

    ////////////////////////////////////////////////////////////
    // Priority state
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            DCACHE_FIRST: begin
                // Icache served on the starved cycle itself needs no switch
                if (starved && !icache_accepted) begin
                    state_next = ICACHE_FIRST;
                end
            end
            ICACHE_FIRST: begin
                if (icache_accepted) begin
                    state_next = DCACHE_FIRST;   // Back to normal order
                end
            end
            default: state_next = DCACHE_FIRST;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= DCACHE_FIRST;
        end else begin
            state <= state_next;
        end
    end

    // Only one cache may see its request taken per cycle
    a_one_accept: assert property (@(posedge clock) disable iff (!rst_n)
        !(icache_accepted && dcache_accepted));

    // A pending request always reaches the bus
    a_cmd_driven: assert property (@(posedge clock) disable iff (!rst_n)
        (icache_req.valid || dcache_req.valid) |-> (proc2mem_command != mem_arb_pkg::MEM_NONE));

endmodule

// File: hw/mem_arbiter/starve_timer.sv
module starve_timer (
    input  logic clock,
    input  logic rst_n,
    input  logic icache_waiting,     // Icache request is valid
    input  logic icache_accepted,    // Memory took the icache request
    output logic starved             // Icache must win next arbitration
);

    logic [mem_arb_pkg::STARVE_CNT_W-1:0] wait_cnt;     // Consecutive lost cycles

    localparam logic [mem_arb_pkg::STARVE_CNT_W-1:0] CNT_MAX =
        mem_arb_pkg::STARVE_CNT_W'(mem_arb_pkg::STARVE_LIMIT);

    ////////////////////////////////////////////////////////////
    // Wait counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (!icache_waiting || icache_accepted) begin
            // Nothing waiting or it just got through
            wait_cnt <= '0;
        end else if (wait_cnt != CNT_MAX) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
        // Saturated, hold until served
    end

    assign starved = (wait_cnt == CNT_MAX);

    // Saturation must hold
    a_cnt_bound: assert property (@(posedge clock) disable iff (!rst_n)
        wait_cnt <= CNT_MAX);

endmodule

// File: hw/mem_arbiter/tag_owner_table.sv
module tag_owner_table (
    input  logic                    clock,
    input  logic                    rst_n,

    // Issue side, from arb_fsm
    input  logic                    load_issued,                // Load accepted this cycle
    input  mem_arb_pkg::requester_e grant_owner,                // Cache that issued it
    input  mem_arb_pkg::mem_tag_t   mem2proc_transaction_tag,   // Tag memory gave it

    // Return side, from memory
    input  mem_arb_pkg::block_t     mem2proc_data,
    input  mem_arb_pkg::mem_tag_t   mem2proc_data_tag,          // 0 = nothing returning

    output mem_arb_pkg::mem_resp_t  icache_resp,
    output mem_arb_pkg::mem_resp_t  dcache_resp
);

    ////////////////////////////////////////////////////////////
    // Table storage, entry i holds tag i+1
    ////////////////////////////////////////////////////////////

    logic                    [mem_arb_pkg::NUM_TAGS-1:0] busy;    // Load outstanding
    mem_arb_pkg::requester_e [mem_arb_pkg::NUM_TAGS-1:0] owner;   // Valid only while busy

    logic [mem_arb_pkg::TAG_W-1:0] issue_idx;   // Entry of the tag being handed out
    logic [mem_arb_pkg::TAG_W-1:0] ret_idx;     // Entry of the tag coming back
    logic                          ret_valid;   // Memory returns data this cycle
    logic                          ret_hit;     // And the tag is one of ours

    // Tag 0 never indexes, both uses below are qualified
    assign issue_idx = mem2proc_transaction_tag - 1'b1;
    assign ret_idx   = mem2proc_data_tag - 1'b1;
    assign ret_valid = (mem2proc_data_tag != '0);
    assign ret_hit   = ret_valid && busy[ret_idx];

    ////////////////////////////////////////////////////////////
    // Response routing
    ////////////////////////////////////////////////////////////

    always_comb begin
        // Tag and data fan out to both, valid picks the owner
        icache_resp.tag  = mem2proc_data_tag;
        icache_resp.data = mem2proc_data;
        dcache_resp.tag  = mem2proc_data_tag;
        dcache_resp.data = mem2proc_data;

        icache_resp.valid = ret_hit && (owner[ret_idx] == mem_arb_pkg::REQ_ICACHE);
        dcache_resp.valid = ret_hit && (owner[ret_idx] == mem_arb_pkg::REQ_DCACHE);
    end

    ////////////////////////////////////////////////////////////
    // Entry update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (ret_valid) begin
                busy[ret_idx] <= 1'b0;      // Data delivered, tag is free again
            end
            if (load_issued) begin
                busy[issue_idx] <= 1'b1;    // Later set wins if memory reuses the tag at once
            end
        end
    end

    // Owner is payload, busy says whether it means anything
    always_ff @(posedge clock) begin
        if (load_issued) begin
            owner[issue_idx] <= grant_owner;
        end
    end

    // Memory only returns tags for loads it accepted earlier
    a_ret_busy: assert property (@(posedge clock) disable iff (!rst_n)
        ret_valid |-> busy[ret_idx]);

    // Memory never hands out a tag still in flight, unless it frees in this cycle
    a_issue_free: assert property (@(posedge clock) disable iff (!rst_n)
        load_issued |-> (!busy[issue_idx] || (ret_valid && ret_idx == issue_idx)));

endmodule

// File: hw/mem_arbiter/mem_arbiter.sv
module mem_arbiter (
    input  logic                     clock,                     // System clock
    input  logic                     rst_n,                     // Sync reset, active low

    // Requests from the two caches
    input  mem_arb_pkg::mem_req_t    icache_req,
    input  mem_arb_pkg::mem_req_t    dcache_req,

    // Memory answers
    input  mem_arb_pkg::mem_tag_t    mem2proc_transaction_tag,  // Nonzero accepts the request
    input  mem_arb_pkg::block_t      mem2proc_data,             // Load data
    input  mem_arb_pkg::mem_tag_t    mem2proc_data_tag,         // Tag of returning data

    // Command bus to memory
    output mem_arb_pkg::mem_command_e proc2mem_command,
    output mem_arb_pkg::addr_t       proc2mem_addr,
    output mem_arb_pkg::block_t      proc2mem_data,

    // Back to the caches
    output logic                     icache_accepted,
    output logic                     dcache_accepted,
    output mem_arb_pkg::mem_tag_t    mem_trxn_tag,              // Same tag seen by both caches
    output mem_arb_pkg::mem_resp_t   icache_resp,
    output mem_arb_pkg::mem_resp_t   dcache_resp
);

    ////////////////////////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////////////////////////

    logic                    starved;       // Timer -> FSM, icache waited too long
    logic                    load_issued;   // FSM -> table, record this tag
    mem_arb_pkg::requester_e grant_owner;   // FSM -> table, who got the bus

    // Both caches watch the same tag and qualify it with their strobe
    assign mem_trxn_tag = mem2proc_transaction_tag;

    // Picks the requester and drives memory
    arb_fsm arb_fsm_instance (
        .clock                    (clock),
        .rst_n                    (rst_n),
        .icache_req               (icache_req),
        .dcache_req               (dcache_req),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .starved                  (starved),
        .proc2mem_command         (proc2mem_command),
        .proc2mem_addr            (proc2mem_addr),
        .proc2mem_data            (proc2mem_data),
        .icache_accepted          (icache_accepted),
        .dcache_accepted          (dcache_accepted),
        .grant_owner              (grant_owner),
        .load_issued              (load_issued)
    );

    // Bounds how long the icache can lose to the dcache
    starve_timer starve_timer_instance (
        .clock           (clock),
        .rst_n           (rst_n),
        .icache_waiting  (icache_req.valid),
        .icache_accepted (icache_accepted),
        .starved         (starved)
    );

    // Remembers who owns each load tag and steers returning data
    tag_owner_table tag_owner_table_instance (
        .clock                    (clock),
        .rst_n                    (rst_n),
        .load_issued              (load_issued),
        .grant_owner              (grant_owner),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data            (mem2proc_data),
        .mem2proc_data_tag        (mem2proc_data_tag),
        .icache_resp              (icache_resp),
        .dcache_resp              (dcache_resp)
    );

endmodule

// File: tb/mem_model.sv
module mem_model (
    input  logic                      clock,
    input  logic                      rst_n,
    input  mem_arb_pkg::mem_command_e proc2mem_command,
    input  mem_arb_pkg::addr_t        proc2mem_addr,
    input  logic                      refuse,                    // Back-pressure this cycle
    input  logic [3:0]                latency,                   // 1 .. 8 cycles to return
    output mem_arb_pkg::mem_tag_t     mem2proc_transaction_tag,
    output mem_arb_pkg::block_t       mem2proc_data,
    output mem_arb_pkg::mem_tag_t     mem2proc_data_tag
);

    logic [mem_arb_pkg::NUM_TAGS:0] busy;                        // Bit 0 unused
    int                             due [mem_arb_pkg::NUM_TAGS+1];
    mem_arb_pkg::addr_t             addr_of [mem_arb_pkg::NUM_TAGS+1];
    int                             cycle;

    ////////////////////////////////////////////////////////////
    // Acceptance, lowest free tag
    ////////////////////////////////////////////////////////////

    always_comb begin
        mem2proc_transaction_tag = '0;
        if (proc2mem_command != mem_arb_pkg::MEM_NONE && !refuse) begin
            for (int t = mem_arb_pkg::NUM_TAGS; t >= 1; t--) begin
                if (!busy[t]) mem2proc_transaction_tag = mem_arb_pkg::mem_tag_t'(t);
            end
        end
    end

    // One return per cycle, lowest due tag first
    always_comb begin
        mem2proc_data_tag = '0;
        mem2proc_data     = '0;
        for (int t = mem_arb_pkg::NUM_TAGS; t >= 1; t--) begin
            if (busy[t] && due[t] <= cycle) begin
                mem2proc_data_tag = mem_arb_pkg::mem_tag_t'(t);
                mem2proc_data     = {2{addr_of[t]}};   // Address twice
            end
        end
    end

    always @(posedge clock) begin
        if (!rst_n) begin
            busy  <= '0;
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
            if (mem2proc_data_tag != '0) busy[mem2proc_data_tag] <= 1'b0;
            // Stores take a tag but never come back
            if (proc2mem_command == mem_arb_pkg::MEM_LOAD && mem2proc_transaction_tag != '0) begin
                busy[mem2proc_transaction_tag]    <= 1'b1;
                due[mem2proc_transaction_tag]     <= cycle + int'(latency);
                addr_of[mem2proc_transaction_tag] <= proc2mem_addr;
            end
        end
    end

endmodule

// File: tb/tb_mem_arbiter.sv
module tb_mem_arbiter;

    localparam int NUM_REQ = 200;               // Per cache
    localparam int TIMEOUT = 3000;              // 400 requests at ~6 cycles, plus margin
    localparam int LIM     = mem_arb_pkg::STARVE_LIMIT;

    logic                      clock;
    logic                      rst_n;
    mem_arb_pkg::mem_req_t     icache_req;
    mem_arb_pkg::mem_req_t     dcache_req;
    mem_arb_pkg::mem_tag_t     mem2proc_transaction_tag;
    mem_arb_pkg::block_t       mem2proc_data;
    mem_arb_pkg::mem_tag_t     mem2proc_data_tag;
    mem_arb_pkg::mem_command_e proc2mem_command;
    mem_arb_pkg::addr_t        proc2mem_addr;
    mem_arb_pkg::block_t       proc2mem_data;
    logic                      icache_accepted;
    logic                      dcache_accepted;
    mem_arb_pkg::mem_tag_t     mem_trxn_tag;
    mem_arb_pkg::mem_resp_t    icache_resp;
    mem_arb_pkg::mem_resp_t    dcache_resp;
    logic                      refuse;
    logic [3:0]                latency;

    mem_arbiter DUT (.*);

    mem_model mem_model (
        .clock(clock), .rst_n(rst_n),
        .proc2mem_command(proc2mem_command), .proc2mem_addr(proc2mem_addr),
        .refuse(refuse), .latency(latency),
        .mem2proc_transaction_tag(mem2proc_transaction_tag),
        .mem2proc_data(mem2proc_data), .mem2proc_data_tag(mem2proc_data_tag)
    );

    logic [15:0] lfsr;
    logic        run_en;
    int          icache_sent, dcache_sent;
    logic [1:0]  icache_gap, dcache_gap;     // Idle cycles before next request
    int          icache_wait_cnt;            // Consecutive unaccepted waiting cycles
    int          icache_lost_cnt;            // Same, counting only memory-accepting cycles
    int          outstanding;                // Loads accepted and not returned
    int          cycle_cnt;
    int          errs [6];
    int          hits [6];
    string       test_name [6] = '{"idle after reset", "dcache priority", "starvation bound",
                                   "handshake and back-pressure", "load routing",
                                   "store handling"};

    // Scoreboard per tag
    logic                    exp_busy  [mem_arb_pkg::NUM_TAGS+1];
    mem_arb_pkg::requester_e exp_owner [mem_arb_pkg::NUM_TAGS+1];
    mem_arb_pkg::addr_t      exp_addr  [mem_arb_pkg::NUM_TAGS+1];

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // Random source
    ////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[14:0], lfsr[15]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic report_value(input int t, input string sig,
                                input logic [63:0] got, input logic [63:0] exp);
        errs[t]++;
        $display("error at %0t: %s is %h, expected %h", $time, sig, got, exp);
    endtask

    task automatic report_text(input int t, input string what);
        errs[t]++;
        $display("at %0t: %s", $time, what);
    endtask

    // New random request for one cache
    task automatic make_req(input logic dside, output mem_arb_pkg::mem_req_t r);
        logic [15:0] v;
        r.valid = 1'b1;
        take_bits(1, v);
        r.command = (dside && v[0]) ? mem_arb_pkg::MEM_STORE : mem_arb_pkg::MEM_LOAD;
        take_bits(12, v);
        r.addr = {17'h0, v[11:0], 3'b000};
        take_bits(16, v);
        r.data = {4{v}};
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus, caches and memory knobs
    ////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        mem_arb_pkg::mem_req_t r;
        logic [15:0]           v;
        if (run_en) begin
            if (icache_req.valid) begin
                if (icache_accepted) begin
                    icache_req.valid <= 1'b0;
                    take_bits(2, v);
                    icache_gap <= v[1:0];
                end
            end else if (icache_gap != 0) begin
                icache_gap <= icache_gap - 1'b1;
            end else if (icache_sent < NUM_REQ) begin
                make_req(1'b0, r);
                icache_req  <= r;
                icache_sent <= icache_sent + 1;
            end
            if (dcache_req.valid) begin
                if (dcache_accepted) begin
                    dcache_req.valid <= 1'b0;
                    take_bits(2, v);
                    dcache_gap <= v[1:0];
                end
            end else if (dcache_gap != 0) begin
                dcache_gap <= dcache_gap - 1'b1;
            end else if (dcache_sent < NUM_REQ) begin
                make_req(1'b1, r);
                dcache_req  <= r;
                dcache_sent <= dcache_sent + 1;
            end
            take_bits(2, v);
            refuse <= (v[1:0] == 2'b00);              // About a quarter refused
            take_bits(3, v);
            latency <= {1'b0, v[2:0]} + 4'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Scoreboard and reference counters
    ////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        if (rst_n) begin
            if (mem2proc_data_tag != '0 && exp_busy[mem2proc_data_tag]) begin
                exp_busy[mem2proc_data_tag] <= 1'b0;
                outstanding <= outstanding - 1;
            end
            if (icache_accepted && icache_req.command == mem_arb_pkg::MEM_LOAD) begin
                exp_busy[mem2proc_transaction_tag]  <= 1'b1;
                exp_owner[mem2proc_transaction_tag] <= mem_arb_pkg::REQ_ICACHE;
                exp_addr[mem2proc_transaction_tag]  <= icache_req.addr;
            end
            if (dcache_accepted && dcache_req.command == mem_arb_pkg::MEM_LOAD) begin
                exp_busy[mem2proc_transaction_tag]  <= 1'b1;
                exp_owner[mem2proc_transaction_tag] <= mem_arb_pkg::REQ_DCACHE;
                exp_addr[mem2proc_transaction_tag]  <= dcache_req.addr;
            end
            if ((icache_accepted && icache_req.command == mem_arb_pkg::MEM_LOAD) ||
                (dcache_accepted && dcache_req.command == mem_arb_pkg::MEM_LOAD)) begin
                outstanding <= outstanding + 1 -
                    ((mem2proc_data_tag != '0 && exp_busy[mem2proc_data_tag]) ? 1 : 0);
            end
            icache_wait_cnt <= (!icache_req.valid || icache_accepted) ? 0 : icache_wait_cnt + 1;
            if (!icache_req.valid || icache_accepted) icache_lost_cnt <= 0;
            else if (mem2proc_transaction_tag != '0) icache_lost_cnt <= icache_lost_cnt + 1;

            // How often each check is reached
            if (!icache_req.valid && !dcache_req.valid && outstanding == 0) hits[0]++;
            if (icache_req.valid && dcache_req.valid && icache_wait_cnt < LIM) hits[1]++;
            if (icache_req.valid) hits[2]++;
            if (mem2proc_transaction_tag == '0 && proc2mem_command != mem_arb_pkg::MEM_NONE)
                hits[3]++;
            if (mem2proc_data_tag != '0) hits[4]++;
            if (mem2proc_transaction_tag != '0 && proc2mem_command == mem_arb_pkg::MEM_STORE)
                hits[5]++;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    a_idle: assert property (@(posedge clock) disable iff (!rst_n)
        (!icache_req.valid && !dcache_req.valid && outstanding == 0) |->
        (proc2mem_command == mem_arb_pkg::MEM_NONE && !icache_accepted && !dcache_accepted &&
         !icache_resp.valid && !dcache_resp.valid))
        else report_text(0, "idle bus shows a command, strobe or response");

    a_dcache_wins: assert property (@(posedge clock) disable iff (!rst_n)
        (icache_req.valid && dcache_req.valid && icache_wait_cnt < LIM) |->
        proc2mem_addr == dcache_req.addr)
        else report_value(1, "proc2mem_addr", 64'(proc2mem_addr), 64'(dcache_req.addr));

    a_starve_bound: assert property (@(posedge clock) disable iff (!rst_n)
        icache_lost_cnt <= LIM)
        else report_text(2, "icache request lost too many accepting cycles");

    a_refused: assert property (@(posedge clock) disable iff (!rst_n)
        (mem2proc_transaction_tag == '0 && proc2mem_command != mem_arb_pkg::MEM_NONE) |->
        (!icache_accepted && !dcache_accepted) ##1
        (($stable(proc2mem_addr) && $stable(proc2mem_command)) ||
         icache_wait_cnt >= LIM || $rose(dcache_req.valid)))
        else report_text(3, "refused request was accepted or left the bus");

    // Both caches see memory's tag unchanged
    a_trxn_tag: assert property (@(posedge clock) disable iff (!rst_n)
        mem_trxn_tag == mem2proc_transaction_tag)
        else report_value(3, "mem_trxn_tag", 64'(mem_trxn_tag),
                          64'(mem2proc_transaction_tag));

    a_icache_owner: assert property (@(posedge clock) disable iff (!rst_n)
        (mem2proc_data_tag != '0) |->
        icache_resp.valid == (exp_owner[mem2proc_data_tag] == mem_arb_pkg::REQ_ICACHE))
        else report_value(4, "icache_resp.valid", 64'(icache_resp.valid),
                          64'(exp_owner[mem2proc_data_tag] == mem_arb_pkg::REQ_ICACHE));

    a_dcache_owner: assert property (@(posedge clock) disable iff (!rst_n)
        (mem2proc_data_tag != '0) |->
        dcache_resp.valid == (exp_owner[mem2proc_data_tag] == mem_arb_pkg::REQ_DCACHE))
        else report_value(4, "dcache_resp.valid", 64'(dcache_resp.valid),
                          64'(exp_owner[mem2proc_data_tag] == mem_arb_pkg::REQ_DCACHE));

    a_icache_tag: assert property (@(posedge clock) disable iff (!rst_n)
        icache_resp.valid |-> icache_resp.tag == mem2proc_data_tag)
        else report_value(4, "icache_resp.tag", 64'(icache_resp.tag), 64'(mem2proc_data_tag));

    a_dcache_tag: assert property (@(posedge clock) disable iff (!rst_n)
        dcache_resp.valid |-> dcache_resp.tag == mem2proc_data_tag)
        else report_value(4, "dcache_resp.tag", 64'(dcache_resp.tag), 64'(mem2proc_data_tag));

    a_icache_data: assert property (@(posedge clock) disable iff (!rst_n)
        icache_resp.valid |-> icache_resp.data == {2{exp_addr[mem2proc_data_tag]}})
        else report_value(4, "icache_resp.data", icache_resp.data,
                          {2{exp_addr[mem2proc_data_tag]}});

    a_dcache_data: assert property (@(posedge clock) disable iff (!rst_n)
        dcache_resp.valid |-> dcache_resp.data == {2{exp_addr[mem2proc_data_tag]}})
        else report_value(4, "dcache_resp.data", dcache_resp.data,
                          {2{exp_addr[mem2proc_data_tag]}});

    // Store payload reaches memory with the accepted request
    a_store_data: assert property (@(posedge clock) disable iff (!rst_n)
        (dcache_accepted && dcache_req.command == mem_arb_pkg::MEM_STORE) |->
        proc2mem_data == dcache_req.data)
        else report_value(5, "proc2mem_data", proc2mem_data, dcache_req.data);

    // Only recorded loads may answer
    a_no_store_resp: assert property (@(posedge clock) disable iff (!rst_n)
        (icache_resp.valid || dcache_resp.valid) |-> exp_busy[mem2proc_data_tag])
        else report_text(5, "response for a tag with no outstanding load");

    always @(posedge clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        int total;
        lfsr = 16'd89;
        rst_n = 1'b0;
        run_en = 1'b0;
        icache_req = '0;
        dcache_req = '0;
        refuse = 1'b0;
        latency = 4'd1;
        icache_sent = 0;
        dcache_sent = 0;
        icache_gap = '0;
        dcache_gap = '0;
        icache_wait_cnt = 0;
        icache_lost_cnt = 0;
        outstanding = 0;
        cycle_cnt = 0;
        total = 0;
        for (int i = 0; i < 6; i++) begin
            errs[i] = 0;
            hits[i] = 0;
        end
        for (int t = 0; t <= mem_arb_pkg::NUM_TAGS; t++) exp_busy[t] = 1'b0;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
        repeat (6) @(posedge clock);        // Idle window for the reset check
        run_en <= 1'b1;
        while (!(icache_sent == NUM_REQ && dcache_sent == NUM_REQ && !icache_req.valid &&
                 !dcache_req.valid && outstanding == 0)) @(posedge clock);
        repeat (10) @(posedge clock);
        for (int i = 0; i < 6; i++) begin
            $display("test %0d %s: %0d cycles checked, %0d errors", i + 1, test_name[i],
                     hits[i], errs[i]);
            total += errs[i];
        end
        $display("6 tests, %0d requests, %0d errors", icache_sent + dcache_sent, total);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: mem_arbiter.f
common/mem_arb_pkg.sv
hw/mem_arbiter/arb_fsm.sv
hw/mem_arbiter/starve_timer.sv
hw/mem_arbiter/tag_owner_table.sv
hw/mem_arbiter/mem_arbiter.sv
tb/mem_model.sv
tb/tb_mem_arbiter.sv

// File: run.sh
#!/bin/bash
# Build and run the mem_arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing \
    -f mem_arbiter.f \
    --top-module tb_mem_arbiter \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_mem_arbiter)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
